//--- src.f
rtl/mul_pkg.sv
rtl/cla_pkg.sv
rtl/mul8_array.sv
rtl/cla_adder.sv
rtl/pp_stage.sv
rtl/sum_stage.sv
rtl/mul16_top.sv
sim/tb_mul16.sv

//--- sim/tb_mul16.sv
// Testbench for the pipelined 16x16 multiplier
// Streams directed and random operand pairs and checks each product in order
`timescale 1ns/10ps

module tb_mul16;
  import mul_pkg::*;

  // Random pairs, and a cycle budget that covers them with gaps and drain
  localparam int NUM_RANDOM     = 2000;
  localparam int TIMEOUT_CYCLES = 2 * NUM_RANDOM + 1000;
  localparam int LATENCY        = 3;

  logic     clk;
  logic     rst_n;
  operand_t a;
  operand_t b;
  logic     in_valid;
  product_t product;
  logic     out_valid;

  // Products still expected from the DUT, oldest first
  product_t exp_q[$];
  product_t expected;
  int       in_count;
  int       out_count;
  int       cycle_count;

  mul16_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .a         (a),
    .b         (b),
    .in_valid  (in_valid),
    .product   (product),
    .out_valid (out_valid)
  );

  always #2 clk = ~clk;

  // Report an error and end the run
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // One pair, presented for a single cycle
  task automatic send_pair(input operand_t x, input operand_t y);
    @(posedge clk);
    a        <= x;
    b        <= y;
    in_valid <= 1'b1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  // Zero, one, all ones and single-byte operands
  task automatic run_corners();
    send_pair(16'h0000, 16'h0000);
    send_pair(16'h0000, 16'hffff);
    send_pair(16'hffff, 16'h0000);
    send_pair(16'h0001, 16'h1234);
    send_pair(16'hbeef, 16'h0001);
    send_pair(16'h0001, 16'h0001);
    send_pair(16'hffff, 16'hffff);
    // Only ll is nonzero
    send_pair(16'h00ff, 16'h00ff);
    // Only hl is nonzero
    send_pair(16'hff00, 16'h00ff);
    // Only lh is nonzero
    send_pair(16'h00ff, 16'hff00);
    // Only hh is nonzero
    send_pair(16'hff00, 16'hff00);
    send_pair(16'h8000, 16'h8000);
    send_pair(16'h0100, 16'h0001);
    send_pair(16'h0001, 16'h0100);
    idle_cycles(2);
  endtask

  // Single set bit against all ones, in both operand positions
  task automatic run_walking_ones();
    for (int i = 0; i < OP_W; i++) begin
      send_pair(operand_t'(1) << i, 16'hffff);
      send_pair(16'hffff, operand_t'(1) << i);
    end
    idle_cycles(1);
  endtask

  // First half back to back, second half with random idle gaps
  task automatic run_random(input int n);
    operand_t ra;
    operand_t rb;
    for (int i = 0; i < n; i++) begin
      ra = operand_t'($urandom_range(16'hffff));
      rb = operand_t'($urandom_range(16'hffff));
      if (i >= n / 2 && $urandom_range(3) == 0) begin
        idle_cycles($urandom_range(1, 3));
      end
      send_pair(ra, rb);
    end
    idle_cycles(1);
  endtask

  // Reference model and in-order product check
  always @(posedge clk) begin
    if (rst_n) begin
      if (out_valid) begin
        assert (exp_q.size() > 0)
          else stop_on_error("out_valid was raised with no product outstanding");
        expected = exp_q.pop_front();
        out_count++;
        assert (product === expected)
          else stop_on_error($sformatf("FAIL t=%0t product expected 0x%08h got 0x%08h",
                                       $time, expected, product));
      end
      if (in_valid) begin
        exp_q.push_back(product_t'(a) * product_t'(b));
        in_count++;
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_on_error($sformatf("Timeout after %0d cycles, %0d products still outstanding",
                              cycle_count, exp_q.size()));
    end
  end

  // Every accepted pair comes out exactly three cycles later
  a_fixed_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
    in_valid |-> ##LATENCY out_valid
  ) else stop_on_error("out_valid did not rise three cycles after an accepted pair");

  // No out_valid without a pair three cycles earlier
  a_no_extra_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid |-> $past(in_valid, LATENCY)
  ) else stop_on_error("out_valid rose without a pair accepted three cycles before");

  a_quiet_in_reset: assert property (
    @(posedge clk) !rst_n |-> !out_valid
  ) else stop_on_error("out_valid was high while reset was asserted");

  a_valid_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(out_valid)
  ) else stop_on_error("out_valid holds an unknown value after reset");

  initial begin
    void'($urandom(40));
    clk         = 1'b0;
    rst_n       = 1'b0;
    a           = '0;
    b           = '0;
    in_valid    = 1'b0;
    in_count    = 0;
    out_count   = 0;
    cycle_count = 0;

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // out_valid must stay low with nothing sent
    idle_cycles(5);

    run_corners();
    run_walking_ones();
    run_random(NUM_RANDOM);

    // Last pair needs the full pipeline latency to come out
    idle_cycles(1);
    idle_cycles(LATENCY + 1);

    assert (out_count == in_count)
      else stop_on_error($sformatf("FAIL t=%0t out_valid count expected %0d got %0d",
                                   $time, in_count, out_count));
    assert (exp_q.size() == 0)
      else stop_on_error("Products were still outstanding at the end of the run");

    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- rtl/mul16_top.sv
// Pipelined 16x16 unsigned multiplier
// Byte products in stage one, two lookahead additions after, three cycles in all
`timescale 1ns/10ps

module mul16_top (
  input  logic              clk,
  input  logic              rst_n,
  input  mul_pkg::operand_t a,
  input  mul_pkg::operand_t b,
  input  logic              in_valid,
  output mul_pkg::product_t product,
  output logic              out_valid
);
  import mul_pkg::*;

  // Stage one to reduction
  pp_bundle_t pp;
  logic       pp_valid;

  pp_stage u_pp (
    .clk      (clk),
    .rst_n    (rst_n),
    .a        (a),
    .b        (b),
    .in_valid (in_valid),
    .pp       (pp),
    .pp_valid (pp_valid)
  );

  sum_stage u_sum (
    .clk       (clk),
    .rst_n     (rst_n),
    .pp        (pp),
    .pp_valid  (pp_valid),
    .product   (product),
    .out_valid (out_valid)
  );

endmodule

//--- rtl/sum_stage.sv
// Reduction stage
// Folds the two cross terms into the outer-term word, one addition per cycle
`timescale 1ns/10ps

module sum_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  mul_pkg::pp_bundle_t pp,
  input  logic                pp_valid,
  output mul_pkg::product_t   product,
  output logic                out_valid
);
  import mul_pkg::*;

  product_t        outer_word;
  product_t        lh_shift;
  product_t        mid_sum_next;
  product_t        mid_sum;
  product_t        hl_shift;
  product_t        final_sum;
  logic [PP_W-1:0] hl_q;
  logic            mid_valid;

  // Outer terms do not overlap, so they simply concatenate
  assign outer_word = {pp.hh, pp.ll};
  assign lh_shift   = {{HALF_W{1'b0}}, pp.lh, {HALF_W{1'b0}}};

  cla_adder #(.WIDTH(PROD_W)) u_add_lh (.a(outer_word), .b(lh_shift), .sum(mid_sum_next));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mid_valid <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      mid_valid <= pp_valid;
      out_valid <= mid_valid;
    end
  end

  // hl travels with the partial sum for the second add
  always_ff @(posedge clk) begin
    if (pp_valid) begin
      mid_sum <= mid_sum_next;
      hl_q    <= pp.hl;
    end
  end

  assign hl_shift = {{HALF_W{1'b0}}, hl_q, {HALF_W{1'b0}}};

  cla_adder #(.WIDTH(PROD_W)) u_add_hl (.a(mid_sum), .b(hl_shift), .sum(final_sum));

  always_ff @(posedge clk) begin
    if (mid_valid) begin
      product <= final_sum;
    end
  end

  // A presented result must come from loaded stage registers
  a_product_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown(product)
  );

endmodule

//--- rtl/pp_stage.sv
// Partial-product stage
// Four exact 8x8 byte multipliers, results registered with the valid bit
`timescale 1ns/10ps

module pp_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  mul_pkg::operand_t   a,
  input  mul_pkg::operand_t   b,
  input  logic                in_valid,
  output mul_pkg::pp_bundle_t pp,
  output logic                pp_valid
);
  import mul_pkg::*;

  logic [PP_W-1:0] ll_p;
  logic [PP_W-1:0] hl_p;
  logic [PP_W-1:0] lh_p;
  logic [PP_W-1:0] hh_p;

  // Byte products
  mul8_array u_mul_ll (.x(a[HALF_W-1:0]),    .y(b[HALF_W-1:0]),    .p(ll_p));
  mul8_array u_mul_hl (.x(a[OP_W-1:HALF_W]), .y(b[HALF_W-1:0]),    .p(hl_p));
  mul8_array u_mul_lh (.x(a[HALF_W-1:0]),    .y(b[OP_W-1:HALF_W]), .p(lh_p));
  mul8_array u_mul_hh (.x(a[OP_W-1:HALF_W]), .y(b[OP_W-1:HALF_W]), .p(hh_p));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pp_valid <= 1'b0;
    end else begin
      pp_valid <= in_valid;
    end
  end

  // Payload only loads on a valid pair
  always_ff @(posedge clk) begin
    if (in_valid) begin
      pp <= '{ll: ll_p, hl: hl_p, lh: lh_p, hh: hh_p};
    end
  end

  // Operands must be fully known when sampled
  a_operands_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    in_valid |-> !$isunknown({a, b})
  );

endmodule

//--- rtl/cla_adder.sv
// Two-level carry-lookahead adder
// 4-bit groups with a group carry network, no carry in or out
`timescale 1ns/10ps

module cla_adder #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  output logic [WIDTH-1:0] sum
);
  import cla_pkg::*;

  localparam int NG = WIDTH / GROUP_W;

  logic [WIDTH-1:0]   p;
  logic [WIDTH-1:0]   g;
  logic [WIDTH-1:0]   c;
  group_pg_t [NG-1:0] grp;
  logic [NG-1:0]      grp_cin;

  if (WIDTH % GROUP_W != 0) begin : g_width_chk
    $error("cla_adder WIDTH %0d is not a multiple of %0d", WIDTH, GROUP_W);
  end

  // Carry into position n, flat sum of products
  // Used at both levels
  function automatic logic lookahead(input logic [WIDTH-1:0] gv,
                                     input logic [WIDTH-1:0] pv,
                                     input logic cin,
                                     input int n);
    logic cy;
    logic term;
    cy = cin;
    for (int m = 0; m < n; m++) begin
      cy &= pv[m];
    end
    for (int i = 0; i < n; i++) begin
      term = gv[i];
      for (int m = i + 1; m < n; m++) begin
        term &= pv[m];
      end
      cy |= term;
    end
    return cy;
  endfunction

  assign p = a ^ b;
  assign g = a & b;

  // Group propagate and generate
  always_comb begin
    for (int k = 0; k < NG; k++) begin
      grp[k].p = &p[k*GROUP_W +: GROUP_W];
      grp[k].g = lookahead(WIDTH'(g[k*GROUP_W +: GROUP_W]),
                           WIDTH'(p[k*GROUP_W +: GROUP_W]), 1'b0, GROUP_W);
    end
  end

  // Second level, carry into every group
  always_comb begin
    logic [WIDTH-1:0] gg;
    logic [WIDTH-1:0] gp;
    gg = '0;
    gp = '0;
    for (int k = 0; k < NG; k++) begin
      gg[k] = grp[k].g;
      gp[k] = grp[k].p;
    end
    for (int k = 0; k < NG; k++) begin
      grp_cin[k] = lookahead(gg, gp, 1'b0, k);
    end
  end

  // Carries inside each group from its carry-in
  always_comb begin
    for (int k = 0; k < NG; k++) begin
      for (int j = 0; j < GROUP_W; j++) begin
        c[k*GROUP_W+j] = lookahead(WIDTH'(g[k*GROUP_W +: GROUP_W]),
                                   WIDTH'(p[k*GROUP_W +: GROUP_W]), grp_cin[k], j);
      end
    end
  end

  assign sum = p ^ c;

endmodule

//--- rtl/mul8_array.sv
// Exact 8x8 unsigned array multiplier
// AND rows reduced by carry-save rows, upper half finished by a ripple row
`timescale 1ns/10ps

module mul8_array (
  input  logic [mul_pkg::HALF_W-1:0] x,
  input  logic [mul_pkg::HALF_W-1:0] y,
  output logic [mul_pkg::PP_W-1:0]   p
);
  import mul_pkg::*;

  localparam int N = HALF_W;

  // Row r holds x gated by y[r]
  logic [N-1:0] and_row [N];
  // Row sums, top bit is the row's own AND bit passed down
  logic [N-1:0] s_row [N];
  logic [N-2:0] c_row [1:N-1];
  // Carries of the final ripple row
  logic [N-2:0] rc;

  always_comb begin
    for (int r = 0; r < N; r++) begin
      and_row[r] = x & {N{y[r]}};
    end
    s_row[0] = and_row[0];

    // First row needs only half adders
    for (int j = 0; j < N - 1; j++) begin
      s_row[1][j] = s_row[0][j+1] ^ and_row[1][j];
      c_row[1][j] = s_row[0][j+1] & and_row[1][j];
    end
    s_row[1][N-1] = and_row[1][N-1];

    // Carry-save rows, carries move down one row
    for (int r = 2; r < N; r++) begin
      for (int j = 0; j < N - 1; j++) begin
        s_row[r][j] = s_row[r-1][j+1] ^ and_row[r][j] ^ c_row[r-1][j];
        c_row[r][j] = (s_row[r-1][j+1] & and_row[r][j]) |
                      (s_row[r-1][j+1] & c_row[r-1][j]) |
                      (and_row[r][j] & c_row[r-1][j]);
      end
      s_row[r][N-1] = and_row[r][N-1];
    end
  end

  always_comb begin
    logic cin;

    // Lower half comes straight off the array edge
    for (int r = 0; r < N; r++) begin
      p[r] = s_row[r][0];
    end

    // Ripple row merges last sums and carries
    for (int j = 0; j < N - 1; j++) begin
      cin = (j == 0) ? 1'b0 : rc[j-1];
      p[N+j] = s_row[N-1][j+1] ^ c_row[N-1][j] ^ cin;
      rc[j]  = (s_row[N-1][j+1] & c_row[N-1][j]) |
               (s_row[N-1][j+1] & cin) |
               (c_row[N-1][j] & cin);
    end
    p[2*N-1] = rc[N-2];
  end

endmodule

//--- rtl/cla_pkg.sv
// Carry-lookahead package
// Group width and the per-group propagate/generate pair
package cla_pkg;

  // Bits per lookahead group
  localparam int GROUP_W = 4;

  // Group-level signals for the second lookahead level
  typedef struct packed {
    logic p;
    logic g;
  } group_pg_t;

endpackage

//--- rtl/mul_pkg.sv
// Multiplier package
// Operand, product and partial-product widths, and the partial-product bundle
package mul_pkg;

  // Operand and half widths
  localparam int OP_W   = 16;
  localparam int HALF_W = OP_W / 2;

  // One 8x8 partial product, and the full product
  localparam int PP_W   = 2 * HALF_W;
  localparam int PROD_W = 2 * OP_W;

  typedef logic [OP_W-1:0]   operand_t;
  typedef logic [PROD_W-1:0] product_t;

  // Four byte-by-byte products
  // hl is high byte of a times low byte of b, lh the reverse
  typedef struct packed {
    logic [PP_W-1:0] ll;
    logic [PP_W-1:0] hl;
    logic [PP_W-1:0] lh;
    logic [PP_W-1:0] hh;
  } pp_bundle_t;

endpackage
